// ==== design/i2si_settings.svh ====
`ifndef I2SI_SETTINGS_SVH
`define I2SI_SETTINGS_SVH

// width of one audio or pattern word
// also the length of one word-select slot in sck periods
`define I2SI_DATA_W 32

// flip-flops per pin synchronizer
// two is the usual minimum for metastability settling
`define I2SI_SYNC_STAGES 2

`endif

// ==== design/i2si_pkg.sv ====
`include "i2si_settings.svh"

package i2si_pkg;

    // one received or generated sample
    typedef logic [`I2SI_DATA_W-1:0] sample_t;

    // channel flag, 0 = left, 1 = right
    typedef logic chan_t;

    localparam chan_t CHAN_LEFT  = 1'b0;
    localparam chan_t CHAN_RIGHT = 1'b1;

endpackage

// ==== design/i2si_cfg_pkg.sv ====
`include "i2si_settings.svh"

package i2si_cfg_pkg;

    // source of the output words
    typedef enum logic {
        MODE_SERIAL = 1'b0,                         // words from the sd pin
        MODE_BIST   = 1'b1                          // counter pattern
    } i2si_mode_e;

    // start value, upper limit and running pattern value
    typedef logic [`I2SI_DATA_W-1:0] bist_val_t;

    // pattern increment
    typedef logic [7:0] bist_inc_t;

endpackage

// ==== design/i2si_pin_sync.sv ====
`timescale 1ns/1ns
`include "i2si_settings.svh"

module i2si_pin_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic sck,
    input  logic ws,
    input  logic sd,
    output logic sck_rise,
    output logic ws_s,
    output logic sd_s
);

    // all three pins share one chain, bit 2 = sck, bit 1 = ws, bit 0 = sd
    logic [`I2SI_SYNC_STAGES-1:0][2:0] sync_q;
    logic [2:0]                        sync_out;
    logic                              sck_d;      // previous synchronized sck

    assign sync_out = sync_q[`I2SI_SYNC_STAGES-1];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync_q <= '0;
        end
        else
        begin
            sync_q <= {sync_q[`I2SI_SYNC_STAGES-2:0], {sck, ws, sd}};
        end
    end

    // edge detect; ws and sd get the same extra register to stay aligned
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_d    <= 1'b0;
            sck_rise <= 1'b0;
            ws_s     <= 1'b0;
            sd_s     <= 1'b0;
        end
        else
        begin
            sck_d    <= sync_out[2];
            sck_rise <= sync_out[2] & ~sck_d;       // one pulse per sck rising edge
            ws_s     <= sync_out[1];
            sd_s     <= sync_out[0];
        end
    end

endmodule

// ==== design/i2si_deser.sv ====
`timescale 1ns/1ns
`include "i2si_settings.svh"

module i2si_deser
    import i2si_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    sck_rise,
    input  logic    ws_s,
    input  logic    sd_s,
    output logic    slot_done,
    output sample_t slot_word,
    output chan_t   slot_chan
);

    sample_t shift_q;                               // bits of the running slot, MSB first
    sample_t shift_nxt;
    logic    ws_prev;                               // ws seen at the previous sck edge
    logic    ws_change;

    // word including the bit sampled at this edge
    assign shift_nxt = {shift_q[`I2SI_DATA_W-2:0], sd_s};
    assign ws_change = sck_rise && (ws_s != ws_prev);

    always_ff @(posedge clk)
    begin
        if (sck_rise)
        begin
            shift_q <= shift_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ws_prev <= 1'b0;
        end
        else if (sck_rise)
        begin
            ws_prev <= ws_s;
        end
    end

    // finished word, one cycle after the edge that shows the ws change
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            slot_done <= 1'b0;
            slot_chan <= CHAN_LEFT;
        end
        else
        begin
            slot_done <= ws_change;
            if (ws_change)
            begin
                slot_chan <= chan_t'(ws_prev);      // word belongs to the old channel
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (ws_change)
        begin
            slot_word <= shift_nxt;                 // last bit taken is the LSB
        end
    end

endmodule

// ==== design/i2si_bist_gen.sv ====
`timescale 1ns/1ns
`include "i2si_settings.svh"

module i2si_bist_gen
    import i2si_pkg::*;
    import i2si_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      bist_load,
    input  logic      bist_step,
    input  bist_val_t bist_start,
    input  bist_val_t bist_limit,
    input  bist_inc_t bist_inc,
    output sample_t   bist_word
);

    bist_val_t               value_q;
    logic [`I2SI_DATA_W:0]   sum;                  // one extra bit so the compare sees overflow
    logic                    wrap;
    bist_val_t               value_nxt;

    assign sum  = {1'b0, value_q} + {{(`I2SI_DATA_W + 1 - $bits(bist_inc_t)){1'b0}}, bist_inc};
    assign wrap = sum > {1'b0, bist_limit};

    // next value for a step, back to start once the limit would be passed
    always_comb
    begin
        if (wrap)
        begin
            value_nxt = bist_start;
        end
        else
        begin
            value_nxt = sum[`I2SI_DATA_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            value_q <= '0;
        end
        else if (bist_load)
        begin
            value_q <= bist_start;                  // load wins over step
        end
        else if (bist_step)
        begin
            value_q <= value_nxt;
        end
    end

    assign bist_word = sample_t'(value_q);

endmodule

// ==== design/i2si_ctrl.sv ====
`timescale 1ns/1ns

module i2si_ctrl
    import i2si_pkg::*;
    import i2si_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       enable,
    input  i2si_mode_e mode,
    input  logic       slot_done,
    input  sample_t    slot_word,
    input  chan_t      slot_chan,
    input  sample_t    bist_word,
    output logic       bist_load,
    output logic       bist_step,
    output logic       out_req,
    output sample_t    out_data,
    output logic       out_right,
    input  logic       out_ack,
    output logic       overrun
);

    typedef enum logic [1:0] {
        IDLE,                                       // waiting for a slot
        REQ,                                        // out_req high, waiting for ack
        WAIT_ACK_LOW                                // req dropped, waiting for ack to fall
    } ctrl_state_e;

    ctrl_state_e state_q;
    ctrl_state_e state_nxt;
    logic        slot_valid;
    logic        accept;

    assign slot_valid = enable && slot_done;
    assign accept     = slot_valid && (state_q == IDLE);

    // pattern reloads while disabled and moves once per slot, dropped or not
    assign bist_load = ~enable;
    assign bist_step = slot_valid && (mode == MODE_BIST);

    assign out_req = (state_q == REQ);

    always_comb
    begin
        state_nxt = state_q;
        case (state_q)
            IDLE:
            begin
                if (accept)
                begin
                    state_nxt = REQ;
                end
            end
            REQ:
            begin
                if (out_ack)
                begin
                    state_nxt = WAIT_ACK_LOW;
                end
            end
            WAIT_ACK_LOW:
            begin
                if (!out_ack)
                begin
                    state_nxt = IDLE;
                end
            end
            default:
            begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= IDLE;
            overrun <= 1'b0;
        end
        else
        begin
            state_q <= state_nxt;
            if (slot_valid && (state_q != IDLE))
            begin
                overrun <= 1'b1;                    // sticky until reset
            end
        end
    end

    // word and channel held for the whole handshake
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            out_data  <= (mode == MODE_BIST) ? bist_word : slot_word;
            out_right <= slot_chan;
        end
    end

endmodule

// ==== design/i2si_top.sv ====
`timescale 1ns/1ns

module i2si_top
    import i2si_pkg::*;
    import i2si_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sck,
    input  logic       ws,
    input  logic       sd,
    input  logic       enable,
    input  i2si_mode_e mode,
    input  bist_val_t  bist_start,
    input  bist_inc_t  bist_inc,
    input  bist_val_t  bist_limit,
    output logic       out_req,
    output sample_t    out_data,
    output logic       out_right,
    input  logic       out_ack,
    output logic       overrun
);

    logic    sck_rise;
    logic    ws_s;
    logic    sd_s;
    logic    slot_done;
    sample_t slot_word;
    chan_t   slot_chan;
    logic    bist_load;
    logic    bist_step;
    sample_t bist_word;

    i2si_pin_sync u_pin_sync (
        .clk      (clk),
        .rst_n    (rst_n),
        .sck      (sck),
        .ws       (ws),
        .sd       (sd),
        .sck_rise (sck_rise),
        .ws_s     (ws_s),
        .sd_s     (sd_s)
    );

    i2si_deser u_deser (
        .clk       (clk),
        .rst_n     (rst_n),
        .sck_rise  (sck_rise),
        .ws_s      (ws_s),
        .sd_s      (sd_s),
        .slot_done (slot_done),
        .slot_word (slot_word),
        .slot_chan (slot_chan)
    );

    i2si_bist_gen u_bist_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .bist_load  (bist_load),
        .bist_step  (bist_step),
        .bist_start (bist_start),
        .bist_limit (bist_limit),
        .bist_inc   (bist_inc),
        .bist_word  (bist_word)
    );

    i2si_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .mode      (mode),
        .slot_done (slot_done),
        .slot_word (slot_word),
        .slot_chan (slot_chan),
        .bist_word (bist_word),
        .bist_load (bist_load),
        .bist_step (bist_step),
        .out_req   (out_req),
        .out_data  (out_data),
        .out_right (out_right),
        .out_ack   (out_ack),
        .overrun   (overrun)
    );

endmodule

// ==== tb/i2si_assert.sv ====
`timescale 1ns/1ns

module i2si_assert
    import i2si_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    out_req,
    input  sample_t out_data,
    input  logic    out_right,
    input  logic    out_ack
);

    int unsigned fail_count = 0;                    // failed handshake checks

    // req must wait for the consumer
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> out_req)
        else
        begin
            $error("out_req dropped before out_ack was seen");
            fail_count++;
        end

    data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && $past(out_req) |-> $stable(out_data) && $stable(out_right))
        else
        begin
            $error("out_data or out_right changed while out_req was high");
            fail_count++;
        end

    // new word only after the previous ack has gone low
    no_rise_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> !out_ack)
        else
        begin
            $error("out_req rose while out_ack was still high");
            fail_count++;
        end

    req_low_after_reset: assert property (@(posedge clk)
        !rst_n |=> !out_req)
        else
        begin
            $error("out_req high right after reset");
            fail_count++;
        end

endmodule

// ==== tb/i2si_tb.sv ====
`timescale 1ns/1ns
`include "i2si_settings.svh"

module i2si_tb
    import i2si_pkg::*;
    import i2si_cfg_pkg::*;
();

    localparam int CLK_HALF       = 20;
    localparam int RESET_CYCLES   = 16;
    localparam int SCK_HALF       = 4;              // clk cycles per sck half period
    localparam int SLOT_CYCLES    = 2 * SCK_HALF * `I2SI_DATA_W;
    localparam int MID_BIT        = `I2SI_DATA_W / 2;
    localparam int N_SERIAL       = 8;
    localparam int N_WRAP_A       = 30;
    localparam int N_WRAP_B       = 14;
    localparam int N_RELOAD       = 3;
    localparam int N_AFTER        = 3;
    localparam int HOLD_CYCLES    = 600;            // a bit over two slots
    // extra slots cover reconfiguration, the disabled gap and the held ack
    localparam int SLOTS_SENT     = N_SERIAL + N_WRAP_A + N_WRAP_B + N_RELOAD + N_AFTER + 15;
    localparam longint WATCHDOG_NS =
        longint'(RESET_CYCLES + (SLOTS_SENT + 4) * SLOT_CYCLES) * 2 * CLK_HALF;
    localparam logic [31:0] LFSR_SEED = 32'hf482a602;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       sck;
    logic       ws;
    logic       sd;
    logic       enable;
    i2si_mode_e mode;
    bist_val_t  bist_start;
    bist_inc_t  bist_inc;
    bist_val_t  bist_limit;
    logic       out_req;
    sample_t    out_data;
    logic       out_right;
    logic       out_ack;
    logic       overrun;

    int          sck_cnt;
    int          bit_idx;
    chan_t       chan_cur;                          // channel of the slot being sent
    logic [31:0] lfsr;
    logic        bit_val;
    sample_t     shift_word;
    bist_val_t   model_val;                         // predicted pattern value
    sample_t     exp_word;                          // expected word of the last finished slot
    chan_t       exp_chan;

    i2si_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .sck        (sck),
        .ws         (ws),
        .sd         (sd),
        .enable     (enable),
        .mode       (mode),
        .bist_start (bist_start),
        .bist_inc   (bist_inc),
        .bist_limit (bist_limit),
        .out_req    (out_req),
        .out_data   (out_data),
        .out_right  (out_right),
        .out_ack    (out_ack),
        .overrun    (overrun)
    );

    bind i2si_ctrl i2si_assert u_assert (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_req   (out_req),
        .out_data  (out_data),
        .out_right (out_right),
        .out_ack   (out_ack)
    );

    always #(CLK_HALF) clk = ~clk;

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // add the increment and go back to start once the limit would be passed
    function automatic bist_val_t pattern_next(input bist_val_t v);
        longint unsigned stepped;
        stepped = longint'(v) + longint'(bist_inc);
        if (stepped > longint'(bist_limit))
        begin
            pattern_next = bist_start;
        end
        else
        begin
            pattern_next = bist_val_t'(stepped);
        end
    endfunction

    task automatic stop_with_fail(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped on first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        stop_with_fail($sformatf("[FAIL] %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic wait_mid_slot();
        @(negedge clk);
        while (bit_idx != MID_BIT)
        begin
            @(negedge clk);
        end
    endtask

    // consumer side of the four-phase handshake
    task automatic take_word(input string name, input int hold_cycles, input int ack_hold,
                             input bit check);
        sample_t exp_data;
        chan_t   exp_right;
        @(negedge clk);
        while (!out_req)
        begin
            @(negedge clk);
        end
        exp_data  = exp_word;
        exp_right = exp_chan;
        if (check)
        begin
            assert (out_data == exp_data)
                else value_mismatch(name, exp_data, out_data);
            assert (out_right == exp_right)
                else value_mismatch({name, " channel"}, 32'(exp_right), 32'(out_right));
        end
        repeat (hold_cycles) @(posedge clk);
        @(posedge clk);
        out_ack <= 1'b1;
        @(negedge clk);
        while (out_req)
        begin
            @(negedge clk);
        end
        repeat (ack_hold) @(posedge clk);
        @(posedge clk);
        out_ack <= 1'b0;
    endtask

    // enable is only toggled mid-slot and so far from any slot end
    task automatic restart_bist(input bist_val_t start, input bist_inc_t inc,
                                input bist_val_t limit, input int off_cycles);
        wait_mid_slot();
        @(posedge clk);
        enable <= 1'b0;
        repeat (2) @(posedge clk);
        mode       <= MODE_BIST;
        bist_start <= start;
        bist_inc   <= inc;
        bist_limit <= limit;
        repeat (off_cycles) @(posedge clk);
        wait_mid_slot();
        @(posedge clk);
        enable <= 1'b1;
    endtask

    // serial clock, ws and sd, plus the expected word of each slot
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            sck_cnt    = 0;
            bit_idx    = 0;
            chan_cur   = CHAN_LEFT;
            lfsr       = LFSR_SEED;
            shift_word = '0;
            model_val  = '0;
        end
        else
        begin
            if (!enable)
            begin
                model_val = bist_start;             // generator reloads while disabled
            end
            if (sck_cnt == SCK_HALF - 1)
            begin
                sck_cnt = 0;
                sck    <= ~sck;
                if (sck)
                begin
                    bit_val    = lfsr[0];           // next bit on falling sck
                    lfsr       = lfsr_step(lfsr);
                    sd        <= bit_val;
                    shift_word = {shift_word[`I2SI_DATA_W-2:0], bit_val};
                    if (bit_idx == `I2SI_DATA_W - 1)
                    begin
                        ws      <= ~chan_cur;       // ws flips with the LSB
                        exp_chan = chan_cur;
                        exp_word = (mode == MODE_BIST) ? model_val : shift_word;
                        if (enable && (mode == MODE_BIST))
                        begin
                            model_val = pattern_next(model_val);
                        end
                        chan_cur = ~chan_cur;
                        bit_idx  = 0;
                    end
                    else
                    begin
                        ws     <= chan_cur;
                        bit_idx = bit_idx + 1;
                    end
                end
            end
            else
            begin
                sck_cnt = sck_cnt + 1;
            end
        end
    end

    no_req_while_disabled: assert property (@(posedge clk) disable iff (!rst_n)
        !enable |=> !$rose(out_req))
        else stop_with_fail("out_req rose while enable was low");

    overrun_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        !$fell(overrun))
        else stop_with_fail("overrun went low again without a reset");

    always @(negedge clk)
    begin
        if (uut.u_ctrl.u_assert.fail_count != 0)
        begin
            stop_with_fail("a handshake assertion bound to i2si_ctrl failed");
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        stop_with_fail("timeout, the tests did not finish in the expected number of slots");
    end

    initial
    begin
        rst_n      = 1'b0;
        sck        = 1'b0;
        ws         = 1'b0;
        sd         = 1'b0;
        enable     = 1'b0;
        mode       = MODE_SERIAL;
        bist_start = '0;
        bist_inc   = 8'd1;
        bist_limit = '0;
        out_ack    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        wait_mid_slot();
        @(posedge clk);
        enable <= 1'b1;
        take_word("serial", 0, 0, 1'b0);            // first slot after reset
        repeat (N_SERIAL) take_word("serial", 0, 0, 1'b1);

        restart_bist(32'h1, 8'h1, 32'h19, 2);
        repeat (N_WRAP_A) take_word("bist_wrap_a", 0, 0, 1'b1);
        restart_bist(32'h100, 8'h30, 32'h200, 2);
        repeat (N_WRAP_B) take_word("bist_wrap_b", 0, 0, 1'b1);

        // two full slots with enable low
        restart_bist(32'h55, 8'h30, 32'h200, 2 * SLOT_CYCLES);
        repeat (N_RELOAD) take_word("reload", 0, 0, 1'b1);

        @(negedge clk);
        assert (overrun == 1'b0)
            else value_mismatch("overrun before back-pressure", 32'd0, 32'(overrun));
        take_word("backpressure", HOLD_CYCLES, 0, 1'b1);
        @(negedge clk);
        assert (overrun == 1'b1)
            else value_mismatch("overrun after back-pressure", 32'd1, 32'(overrun));
        // ack stays high over two slot ends while the controller waits for it to fall
        take_word("ack_held_high", 0, HOLD_CYCLES, 1'b1);
        repeat (N_AFTER) take_word("after_overrun", 0, 0, 1'b1);
        @(negedge clk);
        assert (overrun == 1'b1)
            else value_mismatch("overrun at end", 32'd1, 32'(overrun));

        repeat (4) @(posedge clk);
        if (uut.u_ctrl.u_assert.fail_count == 0)
        begin
            $display(">>> PASS");
            $finish;
        end
        else
        begin
            stop_with_fail("a handshake assertion bound to i2si_ctrl failed");
        end
    end

endmodule

// ==== flist.f ====
+incdir+design
design/i2si_pkg.sv
design/i2si_cfg_pkg.sv
design/i2si_pin_sync.sv
design/i2si_deser.sv
design/i2si_bist_gen.sv
design/i2si_ctrl.sv
design/i2si_top.sv
tb/i2si_assert.sv
tb/i2si_tb.sv

// ==== Bender.yml ====
package:
  name: i2si

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/i2si_pkg.sv
      - design/i2si_cfg_pkg.sv
      - design/i2si_pin_sync.sv
      - design/i2si_deser.sv
      - design/i2si_bist_gen.sv
      - design/i2si_ctrl.sv
      - design/i2si_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/i2si_assert.sv
      - tb/i2si_tb.sv
